/* src/ufiPkg.sv */
// UFI memory bus shared definitions
// Bus widths, bank geometry and the dual view of the bus address
`default_nettype none

package ufiPkg;

	// ----------------------------------------
	// Bus geometry
	// ----------------------------------------
	localparam int ufiBusWidth   = 32;  // Data word width
	localparam int ufiAdrsBits   = 10;  // Full bus address

	// ----------------------------------------
	// Bank geometry
	// ----------------------------------------
	localparam int ufiBankCount  = 4;   // RAM banks on the slave bus
	localparam int ufiBankBits   = 2;   // Bank select field
	localparam int ufiOffsetBits = 8;   // Word offset inside one bank
	localparam int ufiBankWords  = 1 << ufiOffsetBits; // Depth per bank

	// Bus address, seen flat by masters and split by the banks
	// Bank field sits on top, offset below
	typedef union packed
	{
		logic [ufiAdrsBits-1:0] flat;    // Whole address
		struct packed
		{
			logic [ufiBankBits-1:0]   bank;   // Upper bits pick the bank
			logic [ufiOffsetBits-1:0] offset; // Word inside the bank
		} split;
	} ufiAdrs_u;

endpackage

`default_nettype wire

/* src/ufiArbiter.sv */
// UFI bus arbiter
// Fixed priority MCS > SPI > ATB > VTB, one grant per cycle
// Winning request is registered onto the shared slave bus
// ATB and VTB keep the slot while their request stays valid
`default_nettype none

module ufiArbiter
	import ufiPkg::*;
(
	input  logic                   iUfiClk,
	input  logic                   arstN,
	// MCS, write only
	input  logic [ufiBusWidth-1:0] mcsWd,
	input  logic [ufiAdrsBits-1:0] mcsAdrs,
	input  logic                   mcsEd,
	input  logic                   mcsVd,
	// SPI, write only
	input  logic [ufiBusWidth-1:0] spiWd,
	input  logic [ufiAdrsBits-1:0] spiAdrs,
	input  logic                   spiEd,
	input  logic                   spiVd,
	// VTB, read and write
	input  logic [ufiBusWidth-1:0] vtbWd,
	input  logic [ufiAdrsBits-1:0] vtbAdrs,
	input  logic                   vtbEd,
	input  logic                   vtbVd,
	input  logic                   vtbCmd,   // 1 read, 0 write
	// ATB, read only
	input  logic [ufiAdrsBits-1:0] atbAdrs,
	input  logic                   atbEd,
	input  logic                   atbVd,
	// Grant levels
	output logic                   atbRdy,
	output logic                   vtbRdy,
	// Slave bus
	output logic [ufiBusWidth-1:0] slvWd,
	output logic [ufiAdrsBits-1:0] slvAdrs,
	output logic                   slvEd,
	output logic                   slvCmd    // 1 read, 0 write
);

	// ----------------------------------------
	// Grant decode
	// ----------------------------------------
	logic [ufiBusWidth-1:0] nxtWd;
	ufiAdrs_u               nxtAdrs;
	logic                   nxtEd;
	logic                   nxtCmd;
	logic                   nxtAtbRdy;
	logic                   nxtVtbRdy;

	// Rdy flags double as the memory of who held the slot
	always_comb
	begin
		nxtWd        = '0;
		nxtAdrs.flat = '0;
		nxtEd        = 1'b0;
		nxtCmd       = 1'b0;
		nxtAtbRdy    = 1'b0;
		nxtVtbRdy    = 1'b0;
		casez ({mcsVd, spiVd, atbVd, vtbVd, vtbRdy, atbRdy})
			6'b1?????:                           // MCS always wins
			begin
				nxtWd        = mcsWd;
				nxtAdrs.flat = mcsAdrs;
				nxtEd        = mcsEd;
				nxtCmd       = 1'b0;             // Write only
			end
			6'b01????:
			begin
				nxtWd        = spiWd;
				nxtAdrs.flat = spiAdrs;
				nxtEd        = spiEd;
				nxtCmd       = 1'b0;             // Write only
			end
			6'b001?0?:                           // ATB unless VTB held the slot
			begin
				nxtAdrs.flat = atbAdrs;
				nxtEd        = atbEd;
				nxtCmd       = 1'b1;             // Read only, no write data
				nxtAtbRdy    = 1'b1;
			end
			6'b00?1?0:                           // VTB unless ATB held the slot
			begin
				nxtWd        = vtbWd;
				nxtAdrs.flat = vtbAdrs;
				nxtEd        = vtbEd;
				nxtCmd       = vtbCmd;
				nxtVtbRdy    = 1'b1;
			end
			default:
			begin
				// Idle bus, enable stays low
				nxtEd        = 1'b0;
			end
		endcase
	end

	// ----------------------------------------
	// Slave bus registers
	// ----------------------------------------
	// Control side
	always_ff @(posedge iUfiClk or negedge arstN)
	begin
		if (!arstN)
		begin
			slvEd  <= 1'b0;
			slvCmd <= 1'b0;
			atbRdy <= 1'b0;
			vtbRdy <= 1'b0;
		end
		else
		begin
			slvEd  <= nxtEd;
			slvCmd <= nxtCmd;
			atbRdy <= nxtAtbRdy;  // Grant seen by ATB next cycle
			vtbRdy <= nxtVtbRdy;
		end
	end

	// Payload side
	always_ff @(posedge iUfiClk)
	begin
		slvWd   <= nxtWd;
		slvAdrs <= nxtAdrs.flat;
	end

endmodule

`default_nettype wire

/* src/ufiBankRam.sv */
// UFI RAM bank
// Decodes its own bank field and serves one registered write or read
// Read word and strobe appear one cycle after the bus request
`default_nettype none

module ufiBankRam
	import ufiPkg::*;
#(
	parameter int bankIndex = 0   // Bank field value this bank answers to
)(
	input  logic                   iUfiClk,
	input  logic                   arstN,
	// Slave bus
	input  logic [ufiBusWidth-1:0] slvWd,
	input  logic [ufiAdrsBits-1:0] slvAdrs,
	input  logic                   slvEd,
	input  logic                   slvCmd,   // 1 read, 0 write
	// Read return
	output logic [ufiBusWidth-1:0] bankRd,
	output logic                   bankREd
);

	// ----------------------------------------
	// Address decode
	// ----------------------------------------
	ufiAdrs_u adrsView;
	logic     bankHit;
	logic     wrHit;
	logic     rdHit;

	assign adrsView.flat = slvAdrs;   // Split view below
	assign bankHit       = slvEd && (adrsView.split.bank == ufiBankBits'(bankIndex));
	assign wrHit         = bankHit && !slvCmd;
	assign rdHit         = bankHit && slvCmd;

	// ----------------------------------------
	// Storage
	// ----------------------------------------
	logic [ufiBusWidth-1:0] mem [ufiBankWords];

	// Write port and read data
	always_ff @(posedge iUfiClk)
	begin
		if (wrHit)
		begin
			mem[adrsView.split.offset] <= slvWd;
		end
		if (rdHit)
		begin
			bankRd <= mem[adrsView.split.offset];  // Held until next read
		end
	end

	// One-cycle read strobe
	always_ff @(posedge iUfiClk or negedge arstN)
	begin
		if (!arstN)
		begin
			bankREd <= 1'b0;
		end
		else
		begin
			bankREd <= rdHit;
		end
	end

endmodule

`default_nettype wire

/* src/ufiReadReturn.sv */
// UFI read return
// Picks the one strobing bank and registers its word to the masters
`default_nettype none

module ufiReadReturn
	import ufiPkg::*;
(
	input  logic                                     iUfiClk,
	input  logic                                     arstN,
	// From the banks
	input  logic [ufiBankCount-1:0][ufiBusWidth-1:0] bankRd,
	input  logic [ufiBankCount-1:0]                  bankREd,
	// To the masters
	output logic [ufiBusWidth-1:0]                   rd,
	output logic                                     rdEd
);

	// ----------------------------------------
	// Bank select
	// ----------------------------------------
	logic [ufiBusWidth-1:0] selRd;
	logic                   anyREd;

	// At most one strobe per cycle, so OR is enough
	always_comb
	begin
		selRd = '0;
		for (int i = 0; i < ufiBankCount; i++)
		begin
			selRd = selRd | (bankRd[i] & {ufiBusWidth{bankREd[i]}});
		end
	end

	assign anyREd = |bankREd;

	// ----------------------------------------
	// Output registers
	// ----------------------------------------
	always_ff @(posedge iUfiClk)
	begin
		if (anyREd)
		begin
			rd <= selRd;   // Last word stays on rd
		end
	end

	always_ff @(posedge iUfiClk or negedge arstN)
	begin
		if (!arstN)
		begin
			rdEd <= 1'b0;
		end
		else
		begin
			rdEd <= anyREd;
		end
	end

endmodule

`default_nettype wire

/* src/ufiMemSubsystem.sv */
// UFI memory subsystem top
// Four masters through one arbiter onto a bank of RAMs
// Read words come back on a shared registered return
`default_nettype none

module ufiMemSubsystem
	import ufiPkg::*;
(
	input  logic                   iUfiClk,
	input  logic                   arstN,
	// MCS master
	input  logic [ufiBusWidth-1:0] mcsWd,
	input  logic [ufiAdrsBits-1:0] mcsAdrs,
	input  logic                   mcsEd,
	input  logic                   mcsVd,
	// SPI master
	input  logic [ufiBusWidth-1:0] spiWd,
	input  logic [ufiAdrsBits-1:0] spiAdrs,
	input  logic                   spiEd,
	input  logic                   spiVd,
	// VTB master
	input  logic [ufiBusWidth-1:0] vtbWd,
	input  logic [ufiAdrsBits-1:0] vtbAdrs,
	input  logic                   vtbEd,
	input  logic                   vtbVd,
	input  logic                   vtbCmd,
	output logic                   vtbRdy,
	// ATB master
	input  logic [ufiAdrsBits-1:0] atbAdrs,
	input  logic                   atbEd,
	input  logic                   atbVd,
	output logic                   atbRdy,
	// Shared read return
	output logic [ufiBusWidth-1:0] rd,
	output logic                   rdEd
);

	// ----------------------------------------
	// Internal buses
	// ----------------------------------------
	logic [ufiBusWidth-1:0]                   slvWd;
	logic [ufiAdrsBits-1:0]                   slvAdrs;
	logic                                     slvEd;
	logic                                     slvCmd;
	logic [ufiBankCount-1:0][ufiBusWidth-1:0] bankRd;   // One word per bank
	logic [ufiBankCount-1:0]                  bankREd;

	// Request side
	ufiArbiter uArbiter
	(
		.iUfiClk (iUfiClk),
		.arstN   (arstN),
		.mcsWd   (mcsWd),
		.mcsAdrs (mcsAdrs),
		.mcsEd   (mcsEd),
		.mcsVd   (mcsVd),
		.spiWd   (spiWd),
		.spiAdrs (spiAdrs),
		.spiEd   (spiEd),
		.spiVd   (spiVd),
		.vtbWd   (vtbWd),
		.vtbAdrs (vtbAdrs),
		.vtbEd   (vtbEd),
		.vtbVd   (vtbVd),
		.vtbCmd  (vtbCmd),
		.atbAdrs (atbAdrs),
		.atbEd   (atbEd),
		.atbVd   (atbVd),
		.atbRdy  (atbRdy),
		.vtbRdy  (vtbRdy),
		.slvWd   (slvWd),
		.slvAdrs (slvAdrs),
		.slvEd   (slvEd),
		.slvCmd  (slvCmd)
	);

	// ----------------------------------------
	// RAM banks, one per bank field value
	// ----------------------------------------
	for (genvar g = 0; g < ufiBankCount; g++)
	begin : bankGen
		ufiBankRam #(
			.bankIndex (g)
		) uBank (
			.iUfiClk (iUfiClk),
			.arstN   (arstN),
			.slvWd   (slvWd),
			.slvAdrs (slvAdrs),
			.slvEd   (slvEd),
			.slvCmd  (slvCmd),
			.bankRd  (bankRd[g]),
			.bankREd (bankREd[g])
		);
	end

	// Read side
	ufiReadReturn uReadReturn
	(
		.iUfiClk (iUfiClk),
		.arstN   (arstN),
		.bankRd  (bankRd),
		.bankREd (bankREd),
		.rd      (rd),
		.rdEd    (rdEd)
	);

endmodule

`default_nettype wire

/* testbench/tbUfiMem.sv */
// Testbench for the UFI memory subsystem
// Table of master requests applied one per cycle
// Reference memory and arbitration model predict every read word
`default_nettype none

module tbUfiMem
	import ufiPkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	// ----------------------------------------
	// Stimulus row, one per cycle
	// ----------------------------------------
	typedef struct packed
	{
		logic                   mcsVd;
		logic                   mcsEd;
		logic [ufiAdrsBits-1:0] mcsAdrs;
		logic [ufiBusWidth-1:0] mcsWd;
		logic                   spiVd;
		logic                   spiEd;
		logic [ufiAdrsBits-1:0] spiAdrs;
		logic [ufiBusWidth-1:0] spiWd;
		logic                   atbVd;
		logic                   atbEd;
		logic [ufiAdrsBits-1:0] atbAdrs;
		logic                   vtbVd;
		logic                   vtbEd;
		logic                   vtbCmd;     // 1 read, 0 write
		logic [ufiAdrsBits-1:0] vtbAdrs;
		logic [ufiBusWidth-1:0] vtbWd;
		logic                   chkRdy;     // Row carries a Rdy pair
		logic [1:0]             expRdy;     // {atbRdy, vtbRdy}
	} rowT;

	logic                   iUfiClk;
	logic                   arstN;
	rowT                    cur;        // Row on the DUT inputs
	rowT                    r;          // Row being built
	rowT                    stim [$];
	rowT                    atbReq;     // Read requests held on the inputs in reset
	rowT                    vtbReq;
	logic                   atbRdy;
	logic                   vtbRdy;
	logic [ufiBusWidth-1:0] rd;
	logic                   rdEd;

	// Model state and expectations per cycle
	logic [31:0]            rngState;
	logic [ufiBusWidth-1:0] refMem [2**ufiAdrsBits];
	logic                   heldAtb;    // Slot owner last cycle
	logic                   heldVtb;
	logic                   expRdEd [];
	logic [ufiBusWidth-1:0] expRd [];
	logic                   chkRdyAt [];
	logic [1:0]             expRdyAt [];
	int                     mismatches;
	int                     missingStrobes;
	logic                   built;

	ufiMemSubsystem i_dut
	(
		.iUfiClk (iUfiClk),
		.arstN   (arstN),
		.mcsWd   (cur.mcsWd),
		.mcsAdrs (cur.mcsAdrs),
		.mcsEd   (cur.mcsEd),
		.mcsVd   (cur.mcsVd),
		.spiWd   (cur.spiWd),
		.spiAdrs (cur.spiAdrs),
		.spiEd   (cur.spiEd),
		.spiVd   (cur.spiVd),
		.vtbWd   (cur.vtbWd),
		.vtbAdrs (cur.vtbAdrs),
		.vtbEd   (cur.vtbEd),
		.vtbVd   (cur.vtbVd),
		.vtbCmd  (cur.vtbCmd),
		.vtbRdy  (vtbRdy),
		.atbAdrs (cur.atbAdrs),
		.atbEd   (cur.atbEd),
		.atbVd   (cur.atbVd),
		.atbRdy  (atbRdy),
		.rd      (rd),
		.rdEd    (rdEd)
	);

	initial iUfiClk = 1'b0;
	always #10 iUfiClk = ~iUfiClk;   // 20 ns period

	// ----------------------------------------
	// Table building
	// ----------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Bank on top, offset below
	function automatic logic [ufiAdrsBits-1:0] makeAdrs(input int bank, input int offset);
		return {ufiBankBits'(bank), ufiOffsetBits'(offset)};
	endfunction

	task automatic pushRow();
		stim.push_back(r);
		r = '0;
	endtask

	// Master 0 MCS, 1 SPI, else VTB; fresh random data each call
	task automatic setWrite(input int master, input logic [ufiAdrsBits-1:0] adrs, input logic en);
		rngState = xorshift32(rngState);
		if (master == 0)
		begin
			r.mcsVd   = 1'b1;
			r.mcsEd   = en;
			r.mcsAdrs = adrs;
			r.mcsWd   = rngState;
		end
		else if (master == 1)
		begin
			r.spiVd   = 1'b1;
			r.spiEd   = en;
			r.spiAdrs = adrs;
			r.spiWd   = rngState;
		end
		else
		begin
			r.vtbVd   = 1'b1;
			r.vtbEd   = en;
			r.vtbCmd  = 1'b0;
			r.vtbAdrs = adrs;
			r.vtbWd   = rngState;
		end
	endtask

	task automatic setRead(input logic [ufiAdrsBits-1:0] adrs);
		r.atbVd   = 1'b1;
		r.atbEd   = 1'b1;
		r.atbAdrs = adrs;
	endtask

	// ATB and VTB contention row with its expected grant pair
	task automatic contendRow(input logic atbOn, input logic vtbOn, input logic [1:0] exp);
		if (atbOn)
			setRead(makeAdrs(1, 39));
		r.vtbVd   = vtbOn;
		r.vtbEd   = 1'b1;
		r.vtbCmd  = 1'b1;
		r.vtbAdrs = makeAdrs(3, 53);
		r.chkRdy  = 1'b1;
		r.expRdy  = exp;
		pushRow();
	endtask

	task automatic buildTable();
		for (int k = 0; k < 12; k++)
		begin
			setWrite(k % 3, makeAdrs(k % 4, 32 + 7 * k), 1'b1);  // All banks, all writers
			pushRow();
		end
		setWrite(2, makeAdrs(0, 32), 1'b0);   // Ed low, old word stays
		pushRow();
		setWrite(0, makeAdrs(2, 128), 1'b1);  // SPI loses this one
		setWrite(1, makeAdrs(2, 128), 1'b1);
		pushRow();
		for (int k = 0; k < 12; k++)
		begin
			setRead(makeAdrs(k % 4, 32 + 7 * k));
			pushRow();
			pushRow();                         // Idle gap
		end
		setRead(makeAdrs(2, 128));
		pushRow();
		repeat (3) pushRow();
		// Grant handover between ATB and VTB
		contendRow(1'b1, 1'b1, 2'b10);        // ATB wins from idle
		contendRow(1'b1, 1'b1, 2'b10);
		contendRow(1'b0, 1'b1, 2'b00);        // ATB still held last cycle
		contendRow(1'b0, 1'b1, 2'b01);
		contendRow(1'b1, 1'b1, 2'b01);        // VTB keeps the slot
		contendRow(1'b1, 1'b1, 2'b01);
		repeat (3) pushRow();
		for (int k = 0; k < 8; k++)
		begin
			setRead(makeAdrs(k % 4, 32 + 7 * k));  // Back to back, bank changes each cycle
			pushRow();
		end
		repeat (4) pushRow();                 // Drain the read pipeline
	endtask

	// ----------------------------------------
	// Model and checks
	// ----------------------------------------
	task automatic reportMismatch(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		$display("Mismatch at %0t: %s expected %h, got %h", $time, name, expVal, actVal);
		mismatches++;
	endtask

	// Grants and read strobe all low
	task automatic checkIdleOutputs();
		if (atbRdy !== 1'b0)
			reportMismatch("atbRdy", '0, ufiBusWidth'(atbRdy));
		if (vtbRdy !== 1'b0)
			reportMismatch("vtbRdy", '0, ufiBusWidth'(vtbRdy));
		if (rdEd !== 1'b0)
			reportMismatch("rdEd", '0, ufiBusWidth'(rdEd));
	endtask

	// Row i driven at loop edge i; Rdy due after edge i+1, read after edge i+3
	task automatic modelRow(input int i);
		rowT s;
		logic grantAtb;
		logic grantVtb;
		s        = stim[i];
		grantAtb = 1'b0;
		grantVtb = 1'b0;
		if (s.mcsVd)
		begin
			if (s.mcsEd)
				refMem[s.mcsAdrs] = s.mcsWd;
		end
		else if (s.spiVd)
		begin
			if (s.spiEd)
				refMem[s.spiAdrs] = s.spiWd;
		end
		else if (s.atbVd && !heldVtb)
		begin
			grantAtb = 1'b1;
			expRdEd[i + 3] = s.atbEd;
			expRd[i + 3]   = refMem[s.atbAdrs];
		end
		else if (s.vtbVd && !heldAtb)
		begin
			grantVtb = 1'b1;
			expRdEd[i + 3] = s.vtbEd && s.vtbCmd;
			expRd[i + 3]   = refMem[s.vtbAdrs];
			if (s.vtbEd && !s.vtbCmd)
				refMem[s.vtbAdrs] = s.vtbWd;
		end
		heldAtb         = grantAtb;
		heldVtb         = grantVtb;
		chkRdyAt[i + 1] = s.chkRdy;
		expRdyAt[i + 1] = s.expRdy;
	endtask

	task automatic checkCycle(input int i);
		if (chkRdyAt[i] && atbRdy !== expRdyAt[i][1])
			reportMismatch("atbRdy", ufiBusWidth'(expRdyAt[i][1]), ufiBusWidth'(atbRdy));
		if (chkRdyAt[i] && vtbRdy !== expRdyAt[i][0])
			reportMismatch("vtbRdy", ufiBusWidth'(expRdyAt[i][0]), ufiBusWidth'(vtbRdy));
		if (expRdEd[i] && rdEd !== 1'b1)
		begin
			$display("Read strobe missing at %0t, rdEd stayed low for an expected read", $time);
			missingStrobes++;
		end
		else if (!expRdEd[i] && rdEd !== 1'b0)
			reportMismatch("rdEd", '0, ufiBusWidth'(rdEd));
		else if (expRdEd[i] && rd !== expRd[i])
			reportMismatch("rd", expRd[i], rd);
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial
	begin
		$timeformat(-9, 0, " ns", 0);
		cur            = '0;   // Every DUT input idle
		r              = '0;
		arstN          = 1'b0;
		built          = 1'b0;
		rngState       = 32'h12dee5fc;
		heldAtb        = 1'b0;
		heldVtb        = 1'b0;
		mismatches     = 0;
		missingStrobes = 0;
		buildTable();
		atbReq         = '0;
		atbReq.atbVd   = 1'b1;
		atbReq.atbEd   = 1'b1;
		vtbReq         = '0;
		vtbReq.vtbVd   = 1'b1;
		vtbReq.vtbEd   = 1'b1;
		vtbReq.vtbCmd  = 1'b1;
		expRdEd  = new[stim.size() + 4];
		expRd    = new[stim.size() + 4];
		chkRdyAt = new[stim.size() + 4];
		expRdyAt = new[stim.size() + 4];
		for (int j = 0; j < stim.size() + 4; j++)
		begin
			expRdEd[j]  = 1'b0;
			chkRdyAt[j] = 1'b0;
		end
		built = 1'b1;
		// Reset must mask live read requests from ATB, then VTB
		for (int c = 0; c < 16; c++)
		begin
			@(posedge iUfiClk);
			if (c < 15)
				cur <= (c < 8) ? atbReq : vtbReq;
			else
			begin
				cur   <= '0;
				arstN <= 1'b1;
			end
			@(negedge iUfiClk);
			checkIdleOutputs();
		end
		@(posedge iUfiClk);
		@(negedge iUfiClk);
		// Out of reset, nothing requested yet
		checkIdleOutputs();
		for (int i = 0; i < stim.size(); i++)
		begin
			@(posedge iUfiClk);
			cur <= stim[i];
			modelRow(i);
			@(negedge iUfiClk);   // Outputs settled mid cycle
			checkCycle(i);
		end
		$display("Run finished: %0d mismatches, %0d missing read strobes",
			mismatches, missingStrobes);
		if (mismatches == 0 && missingStrobes == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// Watchdog, table length plus reset and margin
	initial
	begin
		wait (built === 1'b1);
		#((stim.size() + 16 + 8) * 20 + 100);
		$display("Watchdog expired before the stimulus table finished");
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
src/ufiPkg.sv
src/ufiArbiter.sv
src/ufiBankRam.sv
src/ufiReadReturn.sv
src/ufiMemSubsystem.sv
testbench/tbUfiMem.sv

/* Makefile */
# Verilator build and run of the UFI memory subsystem testbench
# Any variable below can be set on the command line

VERILATOR ?= verilator
TOP       ?= tbUfiMem
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "^TEST PASS$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
